//--- rtl/alu_isa_pkg.sv
package alu_isa_pkg;

	// ========================================================================
	// Architectural view of the unit, as the core sees it
	// ========================================================================

	// Width of the register tag that returns with every result
	localparam int TAG_W = 4;

	// One machine word, used for operands, immediates and results
	typedef logic [31:0] value_t;

	// Opcodes understood by the unit
	// Codes 8 to 15 are not assigned and always return zero
	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_MULI  = 4'd1,
		OP_MUL   = 4'd2,
		OP_MADD  = 4'd3,
		OP_MSUB  = 4'd4,
		OP_NMADD = 4'd5,
		OP_I2F   = 4'd6,
		OP_F2I   = 4'd7
	} alu_op_e;

	// Request from the issue stage
	// The c operand is the addend of the multiply-add family
	typedef struct packed {
		alu_op_e          op;
		value_t           a;
		value_t           b;
		value_t           c;
		value_t           imm;
		logic [TAG_W-1:0] tag;
	} alu_req_t;

	// Response to the writeback stage, tag identifies the target register
	typedef struct packed {
		value_t           value;
		logic [TAG_W-1:0] tag;
	} alu_rsp_t;

endpackage

//--- rtl/alu_op_decode.sv
module alu_op_decode
	import alu_isa_pkg::*;
	import alu_pipe_pkg::*;
(
	input  alu_req_t req_i,
	output mac_ctl_t mac_ctl_o,
	output value_t   mul_a_o,
	output value_t   mul_b_o,
	output value_t   addend_o,
	output value_t   cvt_in_o,
	output flight_t  flight_o
);

	// Operands that never change with the opcode
	assign mul_a_o  = req_i.a;
	assign addend_o = req_i.c;
	assign cvt_in_o = req_i.a;

	// Per opcode the unit, its controls and the second factor
	always_comb begin
		mac_ctl_o     = '0;
		mul_b_o       = req_i.b;
		flight_o.tag  = req_i.tag;
		flight_o.sel  = SEL_NONE;
		case (req_i.op)
			OP_MULI: begin
				// Immediate replaces b as second factor
				mul_b_o      = req_i.imm;
				flight_o.sel = SEL_MAC;
			end
			OP_MUL: begin
				flight_o.sel = SEL_MAC;
			end
			OP_MADD: begin
				mac_ctl_o.use_addend = 1'b1;
				flight_o.sel         = SEL_MAC;
			end
			OP_MSUB: begin
				mac_ctl_o.use_addend = 1'b1;
				mac_ctl_o.sub_addend = 1'b1;
				flight_o.sel         = SEL_MAC;
			end
			OP_NMADD: begin
				// Product is negated first, then c is added
				mac_ctl_o.use_addend     = 1'b1;
				mac_ctl_o.negate_product = 1'b1;
				flight_o.sel             = SEL_MAC;
			end
			OP_I2F:  flight_o.sel = SEL_I2F;
			OP_F2I:  flight_o.sel = SEL_F2I;
			// NOP and unassigned codes return zero
			default: flight_o.sel = SEL_NONE;
		endcase
	end

endmodule

//--- rtl/alu_pipe_pkg.sv
package alu_pipe_pkg;

	import alu_isa_pkg::*;

	// ========================================================================
	// Internal pipeline description
	// ========================================================================

	// Cycles from an accepted request to its response
	localparam int ALU_LAT = 8;

	// Depth of the float conversion pipeline
	localparam int CVT_LAT = 3;

	// Unit whose result is returned at the end of the pipeline
	typedef enum logic [1:0] {
		SEL_NONE = 2'd0,
		SEL_MAC  = 2'd1,
		SEL_I2F  = 2'd2,
		SEL_F2I  = 2'd3
	} unit_sel_e;

	// Controls for the multiply-add datapath
	typedef struct packed {
		logic negate_product;
		logic sub_addend;
		logic use_addend;
	} mac_ctl_t;

	// What travels next to the data so the right result is picked later
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		unit_sel_e        sel;
	} flight_t;

endpackage

//--- rtl/delay_line.sv
module delay_line #(
	parameter type T   = logic,
	parameter int  DEP = 1
) (
	input  logic clk,
	input  logic arst_n_i,
	input  T     d_i,
	output T     q_o
);

	// One register per stage, the oldest entry sits at index DEP-1
	T stage_q [DEP];

	// Plain shift register with no enable
	// Every stage clears on reset so no stale valid or tag escapes
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < DEP; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEP; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// Output is taken after exactly DEP clock edges
	assign q_o = stage_q[DEP-1];

endmodule

//--- rtl/fp_convert.sv
module fp_convert
	import alu_isa_pkg::*;
(
	input  logic   clk,
	input  value_t in_i,
	output value_t i2f_o,
	output value_t f2i_o
);

	// Position of the highest set bit, zero when no bit is set
	function automatic logic [4:0] lead_one(input logic [31:0] v);
		logic [4:0] pos;
		pos = '0;
		for (int i = 0; i < 32; i++) begin
			if (v[i]) begin
				pos = 5'(i);
			end
		end
		return pos;
	endfunction

	logic        i_sign_s1_q;
	logic [31:0] i_mag_s1_q;
	logic        i_sign_s2_q;
	logic        i_zero_s2_q;
	logic [4:0]  i_pos_s2_q;
	logic [31:0] i_mag_s2_q;
	logic [31:0] i_norm;

	logic        f_sign_s1_q;
	logic        f_nan_s1_q;
	logic        f_big_s1_q;
	logic        f_small_s1_q;
	logic [4:0]  f_sh_s1_q;
	logic [22:0] f_man_s1_q;
	logic [31:0] f_full;
	logic [31:0] f_mag_s2_q;
	logic        f_sat_s2_q;
	logic        f_neg_s2_q;

	// ========================================================================
	// Integer to single precision
	// ========================================================================

	// Stage 1 splits sign and magnitude
	// The minimum integer becomes 2^31, which is still right as unsigned
	always_ff @(posedge clk) begin
		i_sign_s1_q <= in_i[31];
		i_mag_s1_q  <= in_i[31] ? -in_i : in_i;
	end

	// Stage 2 locates the leading one, which sets the exponent
	always_ff @(posedge clk) begin
		i_sign_s2_q <= i_sign_s1_q;
		i_mag_s2_q  <= i_mag_s1_q;
		i_pos_s2_q  <= lead_one(i_mag_s1_q);
		i_zero_s2_q <= (i_mag_s1_q == '0);
	end

	// Move the leading one up to bit 31, the hidden bit then drops off
	assign i_norm = i_mag_s2_q << (5'd31 - i_pos_s2_q);

	// Stage 3 packs the word, low mantissa bits are simply cut off
	always_ff @(posedge clk) begin
		if (i_zero_s2_q) begin
			i2f_o <= '0;
		end else begin
			i2f_o <= {i_sign_s2_q, 8'd127 + {3'b000, i_pos_s2_q}, i_norm[30:8]};
		end
	end

	// ========================================================================
	// Single precision to integer
	// ========================================================================

	// Stage 1 classifies the exponent
	// Below the bias the result is zero, from 2^31 upward it saturates
	// Infinity falls into the saturating range as well
	always_ff @(posedge clk) begin
		f_sign_s1_q  <= in_i[31];
		f_nan_s1_q   <= (in_i[30:23] == 8'hff) && (in_i[22:0] != '0);
		f_big_s1_q   <= (in_i[30:23] >= 8'd158);
		f_small_s1_q <= (in_i[30:23] < 8'd127);
		f_sh_s1_q    <= 5'(in_i[30:23] - 8'd127);
		f_man_s1_q   <= in_i[22:0];
	end

	// Mantissa with its hidden bit, binary point sits below bit 23
	assign f_full = {8'h00, 1'b1, f_man_s1_q};

	// Stage 2 aligns the mantissa, the right shift truncates toward zero
	always_ff @(posedge clk) begin
		if (f_small_s1_q) begin
			f_mag_s2_q <= '0;
		end else if (f_sh_s1_q >= 5'd23) begin
			f_mag_s2_q <= f_full << (f_sh_s1_q - 5'd23);
		end else begin
			f_mag_s2_q <= f_full >> (5'd23 - f_sh_s1_q);
		end
		f_sat_s2_q <= f_big_s1_q | f_nan_s1_q;
		// NaN is treated as positive so it saturates to the maximum
		f_neg_s2_q <= f_sign_s1_q & ~f_nan_s1_q;
	end

	// Stage 3 applies saturation and the sign
	always_ff @(posedge clk) begin
		if (f_sat_s2_q) begin
			f2i_o <= f_neg_s2_q ? 32'h8000_0000 : 32'h7fff_ffff;
		end else begin
			f2i_o <= f_neg_s2_q ? -f_mag_s2_q : f_mag_s2_q;
		end
	end

endmodule

//--- rtl/mc_alu.sv
module mc_alu
	import alu_isa_pkg::*;
	import alu_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n_i,
	input  logic     req_valid_i,
	input  mac_ctl_t mac_ctl_i,
	input  value_t   mul_a_i,
	input  value_t   mul_b_i,
	input  value_t   addend_i,
	input  value_t   cvt_in_i,
	input  flight_t  flight_i,
	output logic     rsp_valid_o,
	output alu_rsp_t rsp_o
);

	// Valid bit and bookkeeping, delayed together
	typedef struct packed {
		logic    valid;
		flight_t flight;
	} flight_slot_t;

	// Both converter results share one alignment line
	typedef struct packed {
		value_t i2f;
		value_t f2i;
	} cvt_pair_t;

	flight_slot_t slot_in;
	flight_slot_t slot_q;
	cvt_pair_t    cvt_raw;
	cvt_pair_t    cvt_q;
	value_t       mac_result;

	// ========================================================================
	// Execution units
	// ========================================================================

	// Multiply-add already spans the full unit latency
	mul_add_pipe mul_add_pipe_i (
		.clk      (clk),
		.a_i      (mul_a_i),
		.b_i      (mul_b_i),
		.addend_i (addend_i),
		.ctl_i    (mac_ctl_i),
		.result_o (mac_result)
	);

	fp_convert fp_convert_i (
		.clk   (clk),
		.in_i  (cvt_in_i),
		.i2f_o (cvt_raw.i2f),
		.f2i_o (cvt_raw.f2i)
	);

	// ========================================================================
	// Alignment to the common latency
	// ========================================================================

	assign slot_in = '{valid: req_valid_i, flight: flight_i};

	delay_line #(.T(flight_slot_t), .DEP(ALU_LAT)) flight_dly_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.d_i      (slot_in),
		.q_o      (slot_q)
	);

	// Converter output comes early, hold it until the other units catch up
	delay_line #(.T(cvt_pair_t), .DEP(ALU_LAT - CVT_LAT)) cvt_dly_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.d_i      (cvt_raw),
		.q_o      (cvt_q)
	);

	// Result is chosen by the opcode that travelled with the data
	always_comb begin
		case (slot_q.flight.sel)
			SEL_MAC: rsp_o.value = mac_result;
			SEL_I2F: rsp_o.value = cvt_q.i2f;
			SEL_F2I: rsp_o.value = cvt_q.f2i;
			default: rsp_o.value = '0;
		endcase
	end

	assign rsp_o.tag   = slot_q.flight.tag;
	assign rsp_valid_o = slot_q.valid;

endmodule

//--- rtl/mc_alu_top.sv
module mc_alu_top
	import alu_isa_pkg::*;
	import alu_pipe_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n_i,
	input  logic     req_valid_i,
	input  alu_req_t req_i,
	output logic     rsp_valid_o,
	output alu_rsp_t rsp_o
);

	mac_ctl_t mac_ctl;
	value_t   mul_a;
	value_t   mul_b;
	value_t   addend;
	value_t   cvt_in;
	flight_t  flight;

	// Decode happens in the issue cycle without a register
	alu_op_decode alu_op_decode_i (
		.req_i     (req_i),
		.mac_ctl_o (mac_ctl),
		.mul_a_o   (mul_a),
		.mul_b_o   (mul_b),
		.addend_o  (addend),
		.cvt_in_o  (cvt_in),
		.flight_o  (flight)
	);

	mc_alu mc_alu_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_valid_i (req_valid_i),
		.mac_ctl_i   (mac_ctl),
		.mul_a_i     (mul_a),
		.mul_b_i     (mul_b),
		.addend_i    (addend),
		.cvt_in_i    (cvt_in),
		.flight_i    (flight),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

endmodule

//--- rtl/mul_add_pipe.sv
module mul_add_pipe
	import alu_isa_pkg::*;
	import alu_pipe_pkg::*;
(
	input  logic     clk,
	input  value_t   a_i,
	input  value_t   b_i,
	input  value_t   addend_i,
	input  mac_ctl_t ctl_i,
	output value_t   result_o
);

	// Four working stages, the rest of the latency is plain padding
	localparam int PAD = ALU_LAT - 4;

	logic [31:0] pp_ll_q;
	logic [15:0] pp_lh_q;
	logic [15:0] pp_hl_q;
	value_t      prod_s2_q;
	value_t      prod_s3_q;
	value_t      acc_s4_q;
	value_t      addend_s1_q;
	value_t      addend_s2_q;
	value_t      addend_s3_q;
	mac_ctl_t    ctl_s1_q;
	mac_ctl_t    ctl_s2_q;
	mac_ctl_t    ctl_s3_q;
	value_t      pad_q [PAD];

	// ========================================================================
	// Product, low 32 bits only
	// ========================================================================

	// Stage 1 forms the partial products of the 16-bit halves
	// The high by high product lands above bit 31 and is never needed
	// Cross products only matter in their low 16 bits
	always_ff @(posedge clk) begin
		pp_ll_q     <= 32'(a_i[15:0]) * 32'(b_i[15:0]);
		pp_lh_q     <= a_i[15:0] * b_i[31:16];
		pp_hl_q     <= a_i[31:16] * b_i[15:0];
		addend_s1_q <= addend_i;
		ctl_s1_q    <= ctl_i;
	end

	// Stage 2 adds the cross terms at bit 16, everything wraps at 2^32
	always_ff @(posedge clk) begin
		prod_s2_q   <= pp_ll_q + {pp_lh_q + pp_hl_q, 16'h0000};
		addend_s2_q <= addend_s1_q;
		ctl_s2_q    <= ctl_s1_q;
	end

	// ========================================================================
	// Negate and accumulate
	// ========================================================================

	// Stage 3 negates the product for NMADD
	always_ff @(posedge clk) begin
		prod_s3_q   <= ctl_s2_q.negate_product ? -prod_s2_q : prod_s2_q;
		addend_s3_q <= addend_s2_q;
		ctl_s3_q    <= ctl_s2_q;
	end

	// Stage 4 adds or subtracts the addend, plain multiplies pass through
	always_ff @(posedge clk) begin
		if (!ctl_s3_q.use_addend) begin
			acc_s4_q <= prod_s3_q;
		end else if (ctl_s3_q.sub_addend) begin
			acc_s4_q <= prod_s3_q - addend_s3_q;
		end else begin
			acc_s4_q <= prod_s3_q + addend_s3_q;
		end
	end

	// Padding stages bring the total to the common unit latency
	always_ff @(posedge clk) begin
		pad_q[0] <= acc_s4_q;
		for (int i = 1; i < PAD; i++) begin
			pad_q[i] <= pad_q[i-1];
		end
	end

	assign result_o = pad_q[PAD-1];

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mc_alu -f verilog.f -o tb_mc_alu

# The log decides the outcome, an aborted run has no pass line either
./obj_dir/tb_mc_alu | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

//--- verif/mc_alu_assert.sv
module mc_alu_assert
	import alu_isa_pkg::*;
	import alu_pipe_pkg::*;
(
	input logic     clk,
	input logic     arst_n_i,
	input logic     req_valid_i,
	input alu_req_t req_i,
	input logic     rsp_valid_o,
	input alu_rsp_t rsp_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// =========================================================================
	// Fixed latency pipeline properties
	// =========================================================================

	// Nothing may leave the unit while it is held in reset
	no_rsp_in_reset: assert property (@(posedge clk) !arst_n_i |-> !rsp_valid_o)
		else $error("rsp_valid_o high while arst_n_i is low");

	// Every request yields exactly one response ALU_LAT cycles later
	valid_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
		rsp_valid_o == $past(req_valid_i, ALU_LAT))
		else $error("rsp_valid_o does not follow req_valid_i by the unit latency");

	// The tag comes back unchanged with its own result
	tag_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
		rsp_valid_o |-> rsp_o.tag == $past(req_i.tag, ALU_LAT))
		else $error("rsp_o.tag differs from the tag issued with the request");

endmodule

//--- verif/tb_mc_alu.sv
module tb_mc_alu
	import alu_isa_pkg::*;
	import alu_pipe_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic     clk = 1'b0;
	logic     arst_n_i;
	logic     req_valid_i;
	alu_req_t req_i;
	logic     rsp_valid_o;
	alu_rsp_t rsp_o;

	// Responses still owed by the DUT, oldest first
	alu_rsp_t exp_q [$];

	integer           seed;
	int               errors;
	int               checks;
	logic [TAG_W-1:0] next_tag;

	always #5 clk = ~clk;

	mc_alu_top mc_alu_top_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

	bind mc_alu_top mc_alu_assert mc_alu_assert_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

	// =========================================================================
	// Reference model
	// =========================================================================

	// Signed integer to single precision, mantissa truncated
	function automatic value_t float_of_int(input value_t x);
		logic [31:0] mag;
		logic [31:0] tmp;
		logic [22:0] frac;
		int          e;
		if (x == '0) begin
			return '0;
		end
		mag = x[31] ? (~x + 32'd1) : x;
		// Exponent is the floor of log2 of the magnitude
		e = 0;
		tmp = mag;
		while (tmp > 32'd1) begin
			tmp = tmp >> 1;
			e++;
		end
		if (e >= 23) begin
			frac = 23'(mag >> (e - 23));
		end else begin
			frac = 23'(mag << (23 - e));
		end
		return {x[31], 8'(127 + e), frac};
	endfunction

	// Single precision to signed integer, toward zero with saturation
	function automatic value_t int_of_float(input value_t f);
		logic [7:0]  ex;
		logic [63:0] mant;
		logic [63:0] mag;
		ex = f[30:23];
		if (ex == 8'hff && f[22:0] != '0) begin
			return 32'h7fff_ffff;
		end
		if (ex < 8'd127) begin
			return '0;
		end
		// From 2^31 upward nothing fits, infinity lands here too
		if (ex >= 8'd158) begin
			return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
		end
		mant = {40'd0, 1'b1, f[22:0]};
		if (ex >= 8'd150) begin
			mag = mant << (ex - 8'd150);
		end else begin
			mag = mant >> (8'd150 - ex);
		end
		return f[31] ? 32'(-mag) : 32'(mag);
	endfunction

	// Result of one request, all integer arithmetic wraps at 2^32
	function automatic value_t expected_value(input alu_req_t r);
		value_t prod;
		prod = r.a * r.b;
		case (r.op)
			OP_MULI:  return r.a * r.imm;
			OP_MUL:   return prod;
			OP_MADD:  return prod + r.c;
			OP_MSUB:  return prod - r.c;
			OP_NMADD: return r.c - prod;
			OP_I2F:   return float_of_int(r.a);
			OP_F2I:   return int_of_float(r.a);
			default:  return '0;
		endcase
	endfunction

	// =========================================================================
	// Drivers, monitor and checks
	// =========================================================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic value_t rand_word();
		return $random(seed);
	endfunction

	// Drive one request for one cycle and note what must come back
	task automatic issue(input alu_req_t r);
		alu_rsp_t e;
		@(posedge clk);
		req_valid_i <= 1'b1;
		req_i       <= r;
		e.value = expected_value(r);
		e.tag   = r.tag;
		exp_q.push_back(e);
	endtask

	task automatic issue_op(input logic [3:0] op, input value_t a, input value_t b,
			input value_t c, input value_t imm);
		alu_req_t r;
		r.op  = alu_op_e'(op);
		r.a   = a;
		r.b   = b;
		r.c   = c;
		r.imm = imm;
		r.tag = next_tag;
		next_tag++;
		issue(r);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			req_valid_i <= 1'b0;
		end
	endtask

	// Let every outstanding response drain, bounded in case one is lost
	task automatic wait_drain(input string what);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 40) begin
			@(posedge clk);
			req_valid_i <= 1'b0;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d responses of the %s test never arrived", exp_q.size(), what);
			errors++;
			exp_q.delete();
		end
	endtask

	// Outputs settle after the rising edge, so look at them half a cycle later
	always @(negedge clk) begin : monitor_blk
		alu_rsp_t e;
		if (arst_n_i && rsp_valid_o) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected response at time %0t with no request outstanding", $time);
				errors++;
			end else begin
				e = exp_q.pop_front();
				check_value("rsp_o.value", rsp_o.value, e.value);
				check_value("rsp_o.tag", 32'(rsp_o.tag), 32'(e.tag));
			end
		end
	end

	// =========================================================================
	// Directed tests
	// =========================================================================

	task automatic reset_latency();
		int   lat;
		logic seen;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
		end
		@(posedge clk);
		arst_n_i <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
		end
		issue_op(OP_MUL, 32'd7, 32'hffff_fffd, 32'd0, 32'd0);
		// Count cycles until the single MUL comes back
		lat = 0;
		seen = 1'b0;
		while (!seen && lat < 20) begin
			@(posedge clk);
			req_valid_i <= 1'b0;
			lat++;
			@(negedge clk);
			seen = rsp_valid_o;
		end
		if (!seen) begin
			$display("The single MUL got no response within 20 cycles");
			errors++;
		end else begin
			check_value("latency", 32'(lat), 32'(ALU_LAT));
		end
		wait_drain("reset and latency");
	endtask

	task automatic multiply_family();
		value_t  edge_vals [8];
		alu_op_e ops [5];
		edge_vals = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff,
			32'h8000_0000, 32'h1234_5678, 32'hffff_0000, 32'h0001_ffff};
		ops = '{OP_MULI, OP_MUL, OP_MADD, OP_MSUB, OP_NMADD};
		foreach (ops[k]) begin
			for (int i = 0; i < 8; i++) begin
				issue_op(ops[k], edge_vals[i], edge_vals[(i * 3 + 1) % 8],
					edge_vals[(i + 5) % 8], edge_vals[(i * 5 + 2) % 8]);
			end
			for (int i = 0; i < 12; i++) begin
				issue_op(ops[k], rand_word(), rand_word(), rand_word(), rand_word());
			end
			idle(2);
		end
		wait_drain("multiply family");
	endtask

	task automatic convert_int_cases();
		value_t vals [12];
		vals = '{32'd0, 32'd1, 32'hffff_ffff, 32'd2, 32'd1024, 32'h0100_0000,
			32'h4000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'h0100_0001,
			32'hffff_ff9c, 32'h00ff_ffff};
		for (int i = 0; i < 12; i++) begin
			issue_op(OP_I2F, vals[i], rand_word(), rand_word(), rand_word());
		end
		for (int i = 0; i < 12; i++) begin
			issue_op(OP_I2F, rand_word(), rand_word(), rand_word(), rand_word());
		end
		wait_drain("integer to float");
	endtask

	task automatic convert_float_cases();
		value_t vals [16];
		// 3.75, -2.5, 0.5, just above -1, zeros, 1.0, 2^23+1 and up to the limits
		vals = '{32'h4070_0000, 32'hc020_0000, 32'h3f00_0000, 32'hbf7f_ffff,
			32'h0000_0000, 32'h3f80_0000, 32'h4b00_0001, 32'h4e80_0001,
			32'h4f00_0000, 32'hcf00_0000, 32'h5015_02f9, 32'h7f80_0000,
			32'hff80_0000, 32'h7fc0_0000, 32'hffc0_0001, 32'h8000_0000};
		for (int i = 0; i < 16; i++) begin
			issue_op(OP_F2I, vals[i], rand_word(), rand_word(), rand_word());
		end
		for (int i = 0; i < 12; i++) begin
			issue_op(OP_F2I, rand_word(), rand_word(), rand_word(), rand_word());
		end
		wait_drain("float to integer");
	endtask

	// Random opcodes, invalid codes included, with random tags and gaps
	task automatic mixed_stream();
		alu_req_t r;
		for (int i = 0; i < 64; i++) begin
			r.op  = alu_op_e'(4'($random(seed)));
			r.a   = rand_word();
			r.b   = rand_word();
			r.c   = rand_word();
			r.imm = rand_word();
			r.tag = TAG_W'($random(seed));
			issue(r);
			if (($random(seed) & 7) == 0) begin
				idle(($random(seed) & 1) + 1);
			end
		end
		wait_drain("mixed stream");
	endtask

	initial begin
		seed     = 32'h4f1a2f1b;
		errors   = 0;
		checks   = 0;
		next_tag = '0;
		arst_n_i    <= 1'b0;
		req_valid_i <= 1'b0;
		req_i       <= '0;

		reset_latency();
		multiply_family();
		convert_int_cases();
		convert_float_cases();
		mixed_stream();
		idle(4);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
rtl/alu_isa_pkg.sv
rtl/alu_pipe_pkg.sv
rtl/delay_line.sv
rtl/mul_add_pipe.sv
rtl/fp_convert.sv
rtl/alu_op_decode.sv
rtl/mc_alu.sv
rtl/mc_alu_top.sv
verif/mc_alu_assert.sv
verif/tb_mc_alu.sv
